// ==== hdl/cache_pkg.sv ====
package cache_pkg;

   // address split: tag | index | offset
   localparam int addr_w     = 16;
   localparam int line_bytes = 16;
   localparam int line_w     = 128;
   localparam int index_w    = 5;
   localparam int tag_w      = 7;
   localparam int offset_w   = 4;
   localparam int num_lines  = 32;
   localparam int size_full  = 15;

   typedef logic [addr_w-1:0]     addr_t;
   typedef logic [tag_w-1:0]      tag_t;
   typedef logic [index_w-1:0]    index_t;
   typedef logic [offset_w-1:0]   offset_t;
   typedef logic [line_w-1:0]     line_t;
   typedef logic [line_bytes-1:0] byte_mask_t;
   typedef logic [3:0]            size_t;

   // processor request, rw high for a write
   typedef struct packed {
      logic  rw;
      addr_t addr;
      size_t size;
      line_t wdata;
   } cpu_req_t;

   // memory bus request, addr always line aligned
   typedef struct packed {
      logic  wr;
      addr_t addr;
      line_t wdata;
   } bus_req_t;

   typedef enum logic [3:0] {
      idle, rd, rd_hit, rd_miss, rd_evict,
      wr, wr_hit, wr_miss, wr_evict
   } cache_state_t;

endpackage

// ==== hdl/cache_cpu_port.sv ====
`timescale 1ns/1ns

module cache_cpu_port
   import cache_pkg::*;
(
   input  cpu_req_t   req,
   input  line_t      line_rdata,
   output byte_mask_t byte_mask,
   output line_t      wdata_aligned,
   output line_t      data_read
);

   offset_t                 offset;
   logic [offset_w+2:0]     shift_bits;
   logic [2*line_bytes-1:0] size_ones;
   logic [2*line_bytes-1:0] run_mask;

   assign offset = req.addr[offset_w-1:0];

   // byte offset turned into a bit shift
   assign shift_bits = {offset, 3'b000};

   // contiguous run of size bytes, placed at the offset
   always_comb
   begin
      size_ones = (32'd1 << req.size) - 32'd1;
      run_mask  = size_ones << offset;
   end

   // bytes that would fall past the line end are cut off here
   always_comb
   begin
      if (req.size == size_t'(size_full))
      begin
         byte_mask = '1;
      end
      else
      begin
         byte_mask = run_mask[line_bytes-1:0];
      end
   end

   // write data starts at byte 0 of req.wdata
   assign wdata_aligned = req.wdata << shift_bits;

   // read data, zero filled from the top
   assign data_read = line_rdata >> shift_bits;

   // only power of two sizes up to 8 bytes, or a full line
   always_comb
   begin
      assert final (req.size inside {4'd1, 4'd2, 4'd4, 4'd8, size_t'(size_full)})
         else $error("[ERROR] req.size illegal: 0x%h", req.size);
   end

endmodule

// ==== hdl/cache_tag_store.sv ====
`timescale 1ns/1ns

module cache_tag_store
   import cache_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  addr_t addr,
   input  logic  tag_we,
   input  logic  set_dirty,
   output logic  hit,
   output logic  evict,
   output tag_t  victim_tag
);

   tag_t                 tags [num_lines];
   logic [num_lines-1:0] valid;
   logic [num_lines-1:0] dirty;

   tag_t   req_tag;
   index_t index;
   logic   match;

   assign req_tag = addr[addr_w-1 -: tag_w];
   assign index   = addr[offset_w +: index_w];

   // lookup is combinational on the current address
   assign victim_tag = tags[index];
   assign match      = (tags[index] == req_tag);
   assign hit        = valid[index] && match;

   // a clean victim is simply overwritten by the refill
   assign evict = valid[index] && dirty[index] && !match;

   always_ff @(posedge clk)
   begin
      if (tag_we)
      begin
         tags[index] <= req_tag;
      end
   end

   // refill installs a clean line, a write hit makes it dirty
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         valid <= '0;
         dirty <= '0;
      end
      else if (tag_we)
      begin
         valid[index] <= 1'b1;
         dirty[index] <= 1'b0;
      end
      else if (set_dirty)
      begin
         dirty[index] <= 1'b1;
      end
   end

endmodule

// ==== hdl/cache_data_array.sv ====
`timescale 1ns/1ns

module cache_data_array
   import cache_pkg::*;
(
   input  logic       clk,
   input  index_t     index,
   input  logic       data_we,
   input  logic       fill,
   input  byte_mask_t byte_mask,
   input  line_t      wdata_aligned,
   input  line_t      fill_data,
   output line_t      line_rdata
);

   line_t mem [num_lines];

   // async read of the addressed line
   assign line_rdata = mem[index];

   always_ff @(posedge clk)
   begin
      if (data_we)
      begin
         if (fill)
         begin
            // refill from the bus replaces the whole line
            mem[index] <= fill_data;
         end
         else
         begin
            for (int b = 0; b < line_bytes; b++)
            begin
               if (byte_mask[b])
               begin
                  mem[index][8*b +: 8] <= wdata_aligned[8*b +: 8];
               end
            end
         end
      end
   end

endmodule

// ==== hdl/cache_controller.sv ====
`timescale 1ns/1ns

module cache_controller
   import cache_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic enable,
   input  logic rw,
   input  logic hit,
   input  logic evict,
   input  logic bus_done,
   output logic ready,
   output logic tag_we,
   output logic set_dirty,
   output logic data_we,
   output logic fill,
   output logic start_fill,
   output logic start_evict
);

   cache_state_t state;
   cache_state_t state_next;
   logic         in_miss;
   logic         in_evict_next;
   logic         in_miss_next;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= idle;
      end
      else
      begin
         state <= state_next;
      end
   end

   always_comb
   begin
      state_next = state;
      case (state)
         idle:     if (enable) state_next = rw ? wr : rd;
         rd:       state_next = hit ? rd_hit : (evict ? rd_evict : rd_miss);
         rd_miss:  if (bus_done) state_next = rd_hit;
         rd_evict: if (bus_done) state_next = rd_miss;
         rd_hit:   state_next = idle;
         wr:       state_next = hit ? wr_hit : (evict ? wr_evict : wr_miss);
         wr_miss:  if (bus_done) state_next = wr_hit;
         wr_evict: if (bus_done) state_next = wr_miss;
         wr_hit:   state_next = idle;
         default:  state_next = idle;
      endcase
   end

   assign in_miss       = (state == rd_miss) || (state == wr_miss);
   assign in_miss_next  = (state_next == rd_miss) || (state_next == wr_miss);
   assign in_evict_next = (state_next == rd_evict) || (state_next == wr_evict);

   // refill writes the bus line and installs the tag clean
   assign fill      = in_miss;
   assign tag_we    = in_miss && bus_done;
   assign data_we   = (in_miss && bus_done) || (state == wr_hit);
   assign set_dirty = (state == wr_hit);
   assign ready     = (state == rd_hit) || (state == wr_hit);

   // one cycle pulse in the first cycle of a miss or evict state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         start_fill  <= 1'b0;
         start_evict <= 1'b0;
      end
      else
      begin
         start_fill  <= in_miss_next && (state_next != state);
         start_evict <= in_evict_next && (state_next != state);
      end
   end

   // ready only once the tag store agrees the line is present
   a_ready_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
      ready |-> hit);

   // processor keeps the request up for the whole transaction
   a_enable_held: assert property (@(posedge clk) disable iff (!rst_n)
      (state != idle) && !ready |-> enable);

endmodule

// ==== hdl/cache_bus_port.sv ====
`timescale 1ns/1ns

module cache_bus_port
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     start_fill,
   input  logic     start_evict,
   input  addr_t    addr,
   input  tag_t     victim_tag,
   input  line_t    line_rdata,
   input  logic     bus_r,
   output logic     bus_en,
   output bus_req_t bus,
   output logic     bus_done
);

   logic  wr_q;
   addr_t addr_q;
   line_t wdata_q;

   assign bus_done = bus_en && bus_r;
   assign bus      = '{wr: wr_q, addr: addr_q, wdata: wdata_q};

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         bus_en <= 1'b0;
         wr_q   <= 1'b0;
      end
      else if (start_evict || start_fill)
      begin
         bus_en <= 1'b1;
         wr_q   <= start_evict;
      end
      else if (bus_done)
      begin
         bus_en <= 1'b0;
         wr_q   <= 1'b0;
      end
   end

   // write-back goes to the victim's own line address
   always_ff @(posedge clk)
   begin
      if (start_evict)
      begin
         addr_q  <= {victim_tag, addr[offset_w +: index_w], offset_t'(0)};
         wdata_q <= line_rdata;
      end
      else if (start_fill)
      begin
         addr_q <= {addr[addr_w-1:offset_w], offset_t'(0)};
      end
   end

   a_no_start_open: assert property (@(posedge clk) disable iff (!rst_n)
      (start_fill || start_evict) |-> !bus_en);

   // request fields held while waiting for bus_r
   a_held_until_r: assert property (@(posedge clk) disable iff (!rst_n)
      bus_en && !bus_r |=> $stable(bus));

endmodule

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ns

module cache_top
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     enable,
   input  cpu_req_t req,
   input  logic     bus_r,
   input  line_t    bus_read,
   output line_t    data_read,
   output logic     ready,
   output logic     bus_en,
   output bus_req_t bus
);

   byte_mask_t byte_mask;
   line_t      wdata_aligned;
   line_t      line_rdata;
   logic       hit;
   logic       evict;
   tag_t       victim_tag;
   logic       tag_we;
   logic       set_dirty;
   logic       data_we;
   logic       fill;
   logic       start_fill;
   logic       start_evict;
   logic       bus_done;

   cache_cpu_port i_cpu_port (
      .req           (req),
      .line_rdata    (line_rdata),
      .byte_mask     (byte_mask),
      .wdata_aligned (wdata_aligned),
      .data_read     (data_read)
   );

   cache_controller i_controller (
      .clk         (clk),
      .rst_n       (rst_n),
      .enable      (enable),
      .rw          (req.rw),
      .hit         (hit),
      .evict       (evict),
      .bus_done    (bus_done),
      .ready       (ready),
      .tag_we      (tag_we),
      .set_dirty   (set_dirty),
      .data_we     (data_we),
      .fill        (fill),
      .start_fill  (start_fill),
      .start_evict (start_evict)
   );

   cache_tag_store i_tag_store (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr       (req.addr),
      .tag_we     (tag_we),
      .set_dirty  (set_dirty),
      .hit        (hit),
      .evict      (evict),
      .victim_tag (victim_tag)
   );

   // line index taken straight from the request address
   cache_data_array i_data_array (
      .clk           (clk),
      .index         (req.addr[offset_w +: index_w]),
      .data_we       (data_we),
      .fill          (fill),
      .byte_mask     (byte_mask),
      .wdata_aligned (wdata_aligned),
      .fill_data     (bus_read),
      .line_rdata    (line_rdata)
   );

   cache_bus_port i_bus_port (
      .clk         (clk),
      .rst_n       (rst_n),
      .start_fill  (start_fill),
      .start_evict (start_evict),
      .addr        (req.addr),
      .victim_tag  (victim_tag),
      .line_rdata  (line_rdata),
      .bus_r       (bus_r),
      .bus_en      (bus_en),
      .bus         (bus),
      .bus_done    (bus_done)
   );

endmodule

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb
   import cache_pkg::*;
();

   // stimulus followed by the columns the golden model fills in
   typedef struct packed {
      logic  rw;
      addr_t addr;
      size_t size;
      line_t wdata;
      logic  exp_hit;
      logic  exp_evict;
      addr_t wb_addr;
      line_t wb_data;
      line_t rdata;
   } op_t;

   logic       clk;
   logic       rst_n;
   logic       enable;
   cpu_req_t   req;
   logic       bus_r;
   line_t      bus_read;
   line_t      data_read;
   logic       ready;
   logic       bus_en;
   bus_req_t   bus;
   op_t        ops [$];
   op_t        cur;
   logic [7:0] gold_mem [65536];
   line_t      bus_lines [4096];
   int         n_wr;
   int         n_rd;
   int         n_errors;

   cache_top i_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // fill pattern mixes both address bytes
   function automatic logic [7:0] init_byte(input int a);
      return 8'(a) ^ (8'(a >> 8) * 8'd37) ^ 8'h3c;
   endfunction

   function automatic line_t gold_line(input addr_t a);
      line_t l;
      for (int b = 0; b < line_bytes; b++)
         l[8*b +: 8] = gold_mem[{a[addr_w-1:offset_w], offset_t'(b)}];
      return l;
   endfunction

   task automatic report_mismatch(input string name, input line_t got, input line_t exp);
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      n_errors++;
   endtask

   task automatic report_problem(input string what);
      $display("error at %0t: %s", $time, what);
      n_errors++;
   endtask

   task automatic add_op(input logic rw, input int tag, input int idx, input int off,
                         input int size);
      op_t op;
      op       = '0;
      op.rw    = rw;
      op.addr  = {tag_t'(tag), index_t'(idx), offset_t'(off)};
      op.size  = size_t'(size);
      op.wdata = {$urandom, $urandom, $urandom, $urandom};
      ops.push_back(op);
   endtask

   // golden byte memory plus shadow tags walked once over the whole table
   task automatic build_expected();
      tag_t   sh_tag [num_lines];
      logic   sh_valid [num_lines];
      logic   sh_dirty [num_lines];
      op_t    op;
      index_t idx;
      int     off;
      int     n;
      sh_tag   = '{default: '0};
      sh_valid = '{default: 1'b0};
      sh_dirty = '{default: 1'b0};
      foreach (ops[i])
      begin
         op           = ops[i];
         idx          = op.addr[offset_w +: index_w];
         off          = int'(op.addr[offset_w-1:0]);
         op.exp_hit   = sh_valid[idx] && sh_tag[idx] == op.addr[addr_w-1 -: tag_w];
         op.exp_evict = sh_valid[idx] && sh_dirty[idx] && !op.exp_hit;
         op.wb_addr   = {sh_tag[idx], idx, offset_t'(0)};
         op.wb_data   = gold_line(op.wb_addr);
         op.rdata     = gold_line(op.addr) >> (8 * off);
         n = (op.size == size_t'(size_full)) ? line_bytes : int'(op.size);
         // bytes that would run past the line end are dropped
         for (int b = 0; op.rw && b < n && off + b < line_bytes; b++)
            gold_mem[op.addr + addr_t'(b)] = op.wdata[8*b +: 8];
         if (!op.exp_hit)
         begin
            sh_tag[idx]   = op.addr[addr_w-1 -: tag_w];
            sh_valid[idx] = 1'b1;
         end
         sh_dirty[idx] = op.rw || (op.exp_hit && sh_dirty[idx]);
         ops[i] = op;
      end
   endtask

   task automatic apply_op(input op_t op);
      int cycles;
      cur    = op;
      n_wr   = 0;
      n_rd   = 0;
      cycles = 0;
      req    = '{rw: op.rw, addr: op.addr, size: op.size, wdata: op.wdata};
      enable = 1'b1;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!ready);
      if (!op.rw && data_read !== op.rdata)
         report_mismatch("data_read", data_read, op.rdata);
      if (op.exp_hit && cycles != 2)
         report_problem($sformatf("hit needed %0d cycles to ready", cycles));
      if (n_rd != int'(!op.exp_hit) || n_wr != int'(op.exp_evict))
         report_problem($sformatf("unexpected %0d bus reads, %0d bus writes", n_rd, n_wr));
      enable = 1'b0;
      @(negedge clk);
   endtask

   // memory model answering each request after 1 to 4 cycles
   initial
   begin
      bus_req_t held;
      int       delay;
      addr_t    fill_addr;
      bus_r    = 1'b0;
      bus_read = '0;
      forever
      begin
         @(negedge clk);
         if (bus_en)
         begin
            held  = bus;
            delay = 1 + int'($urandom % 4);
            repeat (delay - 1)
            begin
               @(negedge clk);
               if (!bus_en || bus !== held)
                  report_problem("bus request dropped or changed before bus_r");
            end
            if (held.wr)
            begin
               n_wr++;
               if (n_rd != 0)
                  report_problem("bus write came after the refill read");
               if (held.addr !== cur.wb_addr)
                  report_mismatch("bus.addr", line_t'(held.addr), line_t'(cur.wb_addr));
               if (held.wdata !== cur.wb_data)
                  report_mismatch("bus.wdata", held.wdata, cur.wb_data);
               bus_lines[held.addr[addr_w-1:offset_w]] = held.wdata;
            end
            else
            begin
               n_rd++;
               fill_addr = {cur.addr[addr_w-1:offset_w], offset_t'(0)};
               if (held.addr !== fill_addr)
                  report_mismatch("bus.addr", line_t'(held.addr), line_t'(fill_addr));
               bus_read = bus_lines[held.addr[addr_w-1:offset_w]];
            end
            bus_r = 1'b1;
            @(negedge clk);
            bus_r = 1'b0;
         end
      end
   end

   initial
   begin
      int count;
      count = 0;
      @(posedge clk);
      while (count < 40 * int'(ops.size()) + 50)
      begin
         @(posedge clk);
         count++;
      end
      report_problem("timeout, ready never arrived");
      $display("operations: %0d, errors: %0d", ops.size(), n_errors);
      $display("Some tests failed");
      $finish;
   end

   initial
   begin
      void'($urandom(65583));
      n_errors = 0;
      n_wr     = 0;
      n_rd     = 0;
      rst_n    = 1'b0;
      enable   = 1'b0;
      req      = '{rw: 1'b0, addr: '0, size: 4'd1, wdata: '0};
      for (int a = 0; a < 65536; a++)
      begin
         gold_mem[a] = init_byte(a);
         bus_lines[a / line_bytes][8*(a % line_bytes) +: 8] = init_byte(a);
      end
      // rw, tag, index, offset, size
      add_op(1'b0, 3, 2, 5, 1);
      add_op(1'b0, 3, 2, 0, 1);
      add_op(1'b1, 3, 2, 3, 1);
      add_op(1'b1, 3, 2, 6, 2);
      add_op(1'b1, 3, 2, 8, 4);
      add_op(1'b1, 3, 2, 12, 8);
      add_op(1'b0, 3, 2, 0, 1);
      add_op(1'b1, 3, 5, 0, 15);
      add_op(1'b0, 3, 5, 9, 1);
      // dirty line 2 goes back to memory
      add_op(1'b0, 65, 2, 0, 1);
      add_op(1'b0, 3, 2, 1, 1);
      add_op(1'b0, 16, 7, 0, 1);
      add_op(1'b0, 17, 7, 4, 1);
      add_op(1'b1, 17, 7, 15, 8);
      add_op(1'b0, 17, 8, 0, 1);
      add_op(1'b0, 17, 7, 10, 1);
      // written, then read, then replaced
      add_op(1'b0, 18, 7, 0, 1);
      add_op(1'b1, 127, 31, 7, 1);
      add_op(1'b0, 0, 31, 0, 1);
      add_op(1'b0, 127, 31, 0, 1);
      build_expected();
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      if (bus_en || bus.wr || ready)
         report_problem("bus_en, bus.wr or ready high after reset");
      foreach (ops[i])
         apply_op(ops[i]);
      $display("operations: %0d, errors: %0d", ops.size(), n_errors);
      if (n_errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// ==== sources.f ====
hdl/cache_pkg.sv
hdl/cache_cpu_port.sv
hdl/cache_tag_store.sv
hdl/cache_data_array.sv
hdl/cache_controller.sv
hdl/cache_bus_port.sv
hdl/cache_top.sv
verification/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cache testbench with Verilator, run it, then search the log
verilator --binary --timing --assert --top-module cache_tb -f sources.f -o cache_sim \
   && ./obj_dir/cache_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
